// ==== verilog/cis_pkg.sv ====
package cis_pkg;

////////////////////////////////////////////////////////////////////////////
// sensor sample and timing widths

localparam int adc_w      = 12;                 // adc sample width
localparam int on_cnt_w   = 16;                 // led on-time counter width

typedef logic [adc_w-1:0] adc_sample_t;

localparam adc_sample_t const_pattern = 12'hA5A;    // fixed test pattern

////////////////////////////////////////////////////////////////////////////
// line colour, line mode and pixel source selection

typedef enum logic [1:0]
{
    color_red   = 2'd0,
    color_green = 2'd1,
    color_blue  = 2'd2
} color_t;

typedef enum logic [1:0]
{
    mode_off    = 2'd0,                         // no si, leds dark
    mode_mono   = 2'd1,                         // red only
    mode_rgb    = 2'd2                          // red, green, blue per line
} line_mode_t;

typedef enum logic [1:0]
{
    src_adc     = 2'd0,
    src_ramp    = 2'd1,
    src_const   = 2'd2
} pix_src_t;

// two samples of one line position plus colour and line tag
typedef struct packed
{
    color_t         color;                      // [31:30]
    logic [5:0]     line_idx;                   // [29:24] line number mod 64
    adc_sample_t    samp0;                      // [23:12] even sample
    adc_sample_t    samp1;                      // [11:0]  odd sample
} pix_word_t;

endpackage

// ==== verilog/mem_pkg.sv ====
package mem_pkg;

////////////////////////////////////////////////////////////////////////////
// memory write port

localparam int addr_w     = 28;                 // byte address width
localparam int done_cnt_w = 16;                 // finished buffer counter

typedef logic [addr_w-1:0] mem_addr_t;

localparam mem_addr_t word_bytes = 28'd4;       // one 32-bit word per beat

////////////////////////////////////////////////////////////////////////////
// writer sequencing

typedef enum logic [1:0]
{
    wr_idle     = 2'd0,                         // wait for data and dma_on
    wr_pop      = 2'd1,                         // pop head word
    wr_write    = 2'd2                          // hold beat through waitrequest
} wr_state_t;

endpackage

// ==== verilog/cis_line_sequencer.sv ====
`timescale 1ns/10ps

module cis_line_sequencer
#(
    parameter int LINE_CLKS = 64
)
(
    input  logic                            w_clk_1,
    input  logic                            w_adc_rst,

    input  cis_pkg::line_mode_t             mode,
    input  logic [cis_pkg::on_cnt_w-1:0]    r_on_cnt,
    input  logic [cis_pkg::on_cnt_w-1:0]    g_on_cnt,
    input  logic [cis_pkg::on_cnt_w-1:0]    b_on_cnt,

    output logic                            si,
    output cis_pkg::color_t                 color,
    output logic [2:0]                      lrgb        // active low, bit0 red
);

localparam int pos_w = (LINE_CLKS > 1) ? $clog2(LINE_CLKS) : 1;

logic [pos_w-1:0]               pos_cnt;            // position inside the line
logic                           line_end;
logic                           line_start;
cis_pkg::color_t                color_nxt;
logic [cis_pkg::on_cnt_w-1:0]   on_cnt_nxt;
logic [cis_pkg::on_cnt_w-1:0]   led_left;           // remaining led on cycles
logic                           led_on;

assign line_end   = (pos_cnt == pos_w'(LINE_CLKS - 1));
assign line_start = line_end && (mode != cis_pkg::mode_off);

////////////////////////////////////////////////////////////////////////////
// colour of the coming line and its on-count

always_comb
begin
    if (mode == cis_pkg::mode_rgb)
    begin
        case (color)
            cis_pkg::color_red:     color_nxt = cis_pkg::color_green;
            cis_pkg::color_green:   color_nxt = cis_pkg::color_blue;
            default:                color_nxt = cis_pkg::color_red;
        endcase
    end
    else
    begin
        color_nxt = cis_pkg::color_red;             // mono stays red
    end
end

always_comb
begin
    case (color_nxt)
        cis_pkg::color_green:   on_cnt_nxt = g_on_cnt;
        cis_pkg::color_blue:    on_cnt_nxt = b_on_cnt;
        default:                on_cnt_nxt = r_on_cnt;
    endcase
end

////////////////////////////////////////////////////////////////////////////
// line counter, si strobe and led timer

always_ff @(posedge w_clk_1)
begin
    if (w_adc_rst)
    begin
        pos_cnt  <= '0;
        si       <= 1'b0;
        color    <= cis_pkg::color_blue;            // first rgb line comes out red
        led_left <= '0;
    end
    else
    begin
        pos_cnt <= line_end ? '0 : pos_cnt + 1'b1;  // runs in every mode
        si      <= line_start;

        if (line_start)
        begin
            color    <= color_nxt;
            led_left <= on_cnt_nxt;                 // on from the si cycle
        end
        else if (mode == cis_pkg::mode_off)
        begin
            led_left <= '0;
        end
        else if (led_on)
        begin
            led_left <= led_left - 1'b1;
        end
    end
end

assign led_on = (led_left != '0);
assign lrgb   = led_on ? ~(3'b001 << color) : 3'b111;

endmodule

// ==== verilog/pixel_packer.sv ====
`timescale 1ns/10ps

module pixel_packer
#(
    parameter int PIX_PER_LINE = 16
)
(
    input  logic                    w_clk_1,
    input  logic                    w_adc_rst,

    input  cis_pkg::adc_sample_t    dc,
    input  cis_pkg::pix_src_t       src_sel,
    input  logic                    si,
    input  cis_pkg::color_t         color,

    output cis_pkg::pix_word_t      pix_word,
    output logic                    pix_dv
);

localparam int k_w = (PIX_PER_LINE > 2) ? $clog2(PIX_PER_LINE) : 1;

cis_pkg::adc_sample_t   adc_q;                  // registered adc input
cis_pkg::adc_sample_t   src_val;
cis_pkg::adc_sample_t   first_q;                // even sample of the pair
logic [k_w-1:0]         samp_k;                 // sample index in the line
logic                   samp_act;
logic [5:0]             line_cnt;
logic [5:0]             line_l;
cis_pkg::color_t        color_l;

////////////////////////////////////////////////////////////////////////////
// source select

always_comb
begin
    case (src_sel)
        cis_pkg::src_ramp:  src_val = cis_pkg::adc_sample_t'(samp_k);
        cis_pkg::src_const: src_val = cis_pkg::const_pattern;
        default:            src_val = adc_q;
    endcase
end

////////////////////////////////////////////////////////////////////////////
// sample counter, armed by si

always_ff @(posedge w_clk_1)
begin
    if (w_adc_rst)
    begin
        samp_act <= 1'b0;
        samp_k   <= '0;
        pix_dv   <= 1'b0;
        line_cnt <= '0;
    end
    else
    begin
        pix_dv <= samp_act && samp_k[0];        // word after each odd sample

        if (si)
        begin
            samp_act <= 1'b1;
            samp_k   <= '0;
            line_cnt <= line_cnt + 1'b1;        // wraps at 64
        end
        else if (samp_act)
        begin
            samp_k <= samp_k + 1'b1;
            if (samp_k == k_w'(PIX_PER_LINE - 1))
                samp_act <= 1'b0;               // line done
        end
    end
end

// pair assembly and line tag
always_ff @(posedge w_clk_1)
begin
    adc_q <= dc;

    if (si)
    begin
        color_l <= color;
        line_l  <= line_cnt;
    end

    if (samp_act && !samp_k[0])
        first_q <= src_val;

    if (samp_act && samp_k[0])
    begin
        pix_word.color    <= color_l;
        pix_word.line_idx <= line_l;
        pix_word.samp0    <= first_q;
        pix_word.samp1    <= src_val;
    end
end

endmodule

// ==== verilog/pixel_fifo.sv ====
`timescale 1ns/10ps

module pixel_fifo
#(
    parameter int FIFO_DEPTH  = 16,
    parameter int AFULL_LEVEL = 12
)
(
    input  logic                    w_clk_1,
    input  logic                    w_adc_rst,

    input  cis_pkg::pix_word_t      wr_data,
    input  logic                    wr_en,
    input  logic                    rd_en,

    output cis_pkg::pix_word_t      rd_data,    // head word, show-ahead
    output logic                    empty,
    output logic                    afull,
    output logic                    ovr         // sticky until reset
);

localparam int ptr_w = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
localparam int cnt_w = $clog2(FIFO_DEPTH + 1);

cis_pkg::pix_word_t     mem [FIFO_DEPTH];
logic [ptr_w-1:0]       wr_ptr;
logic [ptr_w-1:0]       rd_ptr;
logic [cnt_w-1:0]       count;
logic                   full;
logic                   wr_ok;
logic                   rd_ok;

function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
    if (p == ptr_w'(FIFO_DEPTH - 1))
        return '0;
    return p + 1'b1;
endfunction

assign full  = (count == cnt_w'(FIFO_DEPTH));
assign empty = (count == '0);
assign afull = (count >= cnt_w'(AFULL_LEVEL));
assign wr_ok = wr_en && !full;                  // writes into a full fifo are lost
assign rd_ok = rd_en && !empty;

assign rd_data = mem[rd_ptr];

always_ff @(posedge w_clk_1)
begin
    if (wr_ok)
        mem[wr_ptr] <= wr_data;
end

////////////////////////////////////////////////////////////////////////////
// pointers, count and overflow

always_ff @(posedge w_clk_1)
begin
    if (w_adc_rst)
    begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
        ovr    <= 1'b0;
    end
    else
    begin
        if (wr_ok)
            wr_ptr <= ptr_inc(wr_ptr);
        if (rd_ok)
            rd_ptr <= ptr_inc(rd_ptr);

        case ({wr_ok, rd_ok})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
        endcase

        if (wr_en && full)
            ovr <= 1'b1;
    end
end

endmodule

// ==== verilog/sdram_writer.sv ====
`timescale 1ns/10ps

module sdram_writer
(
    input  logic                                w_clk_1,
    input  logic                                w_adc_rst,

    input  logic                                dma_on,
    input  mem_pkg::mem_addr_t                  start_adr,
    input  mem_pkg::mem_addr_t                  buf_size,   // in words

    input  cis_pkg::pix_word_t                  fifo_data,
    input  logic                                fifo_empty,
    output logic                                fifo_rd,

    output mem_pkg::mem_addr_t                  mem_address,
    output logic [31:0]                         mem_writedata,
    output logic                                mem_write,
    input  logic                                mem_waitrequest,

    output logic [mem_pkg::done_cnt_w-1:0]      done_cnt
);

mem_pkg::wr_state_t     state;
mem_pkg::mem_addr_t     beat_cnt;               // beats into the current buffer
logic                   leave_idle;
logic                   beat_done;
logic                   buf_end;

assign leave_idle = (state == mem_pkg::wr_idle) && dma_on && !fifo_empty;
assign beat_done  = (state == mem_pkg::wr_write) && !mem_waitrequest;
assign buf_end    = beat_done && (beat_cnt + 1'b1 == buf_size);

assign fifo_rd    = (state == mem_pkg::wr_pop);
assign mem_write  = (state == mem_pkg::wr_write);

////////////////////////////////////////////////////////////////////////////
// beat sequencing

always_ff @(posedge w_clk_1)
begin
    if (w_adc_rst)
    begin
        state    <= mem_pkg::wr_idle;
        beat_cnt <= '0;
        done_cnt <= '0;
    end
    else
    begin
        case (state)
            mem_pkg::wr_idle:
            begin
                if (leave_idle)
                    state <= mem_pkg::wr_pop;
            end
            mem_pkg::wr_pop:
            begin
                state <= mem_pkg::wr_write;     // head word latched here
            end
            mem_pkg::wr_write:
            begin
                if (beat_done)
                    state <= mem_pkg::wr_idle;
            end
            default:
            begin
                state <= mem_pkg::wr_idle;
            end
        endcase

        if (buf_end)
        begin
            beat_cnt <= '0;                     // buffer full so wrap
            done_cnt <= done_cnt + 1'b1;
        end
        else if (beat_done)
        begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end
end

// address and data of the beat, held through waitrequest
always_ff @(posedge w_clk_1)
begin
    if (leave_idle && (beat_cnt == '0))
        mem_address <= start_adr;               // new buffer round
    else if (beat_done)
        mem_address <= mem_address + mem_pkg::word_bytes;

    if (state == mem_pkg::wr_pop)
        mem_writedata <= fifo_data;
end

endmodule

// ==== verilog/scan_top.sv ====
`timescale 1ns/10ps

module scan_top
#(
    parameter int LINE_CLKS    = 64,
    parameter int PIX_PER_LINE = 16,
    parameter int FIFO_DEPTH   = 16,
    parameter int AFULL_LEVEL  = 12
)
(
    input  logic                                w_clk_1,
    input  logic                                w_adc_rst,

    input  cis_pkg::adc_sample_t                dc,
    input  cis_pkg::line_mode_t                 mode,
    input  cis_pkg::pix_src_t                   src_sel,
    input  logic [cis_pkg::on_cnt_w-1:0]        r_on_cnt,
    input  logic [cis_pkg::on_cnt_w-1:0]        g_on_cnt,
    input  logic [cis_pkg::on_cnt_w-1:0]        b_on_cnt,
    output logic [2:0]                          lrgb,
    output logic                                si,

    input  logic                                dma_on,
    input  mem_pkg::mem_addr_t                  start_adr,
    input  mem_pkg::mem_addr_t                  buf_size,
    output mem_pkg::mem_addr_t                  mem_address,
    output logic [31:0]                         mem_writedata,
    output logic                                mem_write,
    input  logic                                mem_waitrequest,
    output logic [mem_pkg::done_cnt_w-1:0]      done_cnt,

    output logic                                fifo_afull,
    output logic                                fifo_ovr
);

cis_pkg::color_t        color;
cis_pkg::pix_word_t     pix_word;
logic                   pix_dv;
cis_pkg::pix_word_t     fifo_data;
logic                   fifo_empty;
logic                   fifo_rd;

////////////////////////////////////////////////////////////////////////////
// sensor side

cis_line_sequencer
#(
    .LINE_CLKS      ( LINE_CLKS     )
)
cis_line_sequencer
(
    .w_clk_1        ( w_clk_1       ),
    .w_adc_rst      ( w_adc_rst     ),
    .mode           ( mode          ),
    .r_on_cnt       ( r_on_cnt      ),
    .g_on_cnt       ( g_on_cnt      ),
    .b_on_cnt       ( b_on_cnt      ),
    .si             ( si            ),  // also drives the packer
    .color          ( color         ),
    .lrgb           ( lrgb          )
);

pixel_packer
#(
    .PIX_PER_LINE   ( PIX_PER_LINE  )
)
pixel_packer
(
    .w_clk_1        ( w_clk_1       ),
    .w_adc_rst      ( w_adc_rst     ),
    .dc             ( dc            ),
    .src_sel        ( src_sel       ),
    .si             ( si            ),
    .color          ( color         ),
    .pix_word       ( pix_word      ),
    .pix_dv         ( pix_dv        )
);

////////////////////////////////////////////////////////////////////////////
// buffering and memory side

pixel_fifo
#(
    .FIFO_DEPTH     ( FIFO_DEPTH    ),
    .AFULL_LEVEL    ( AFULL_LEVEL   )
)
pixel_fifo
(
    .w_clk_1        ( w_clk_1       ),
    .w_adc_rst      ( w_adc_rst     ),
    .wr_data        ( pix_word      ),
    .wr_en          ( pix_dv        ),  // packer is never stalled
    .rd_en          ( fifo_rd       ),
    .rd_data        ( fifo_data     ),
    .empty          ( fifo_empty    ),
    .afull          ( fifo_afull    ),
    .ovr            ( fifo_ovr      )
);

sdram_writer sdram_writer
(
    .w_clk_1            ( w_clk_1           ),
    .w_adc_rst          ( w_adc_rst         ),
    .dma_on             ( dma_on            ),
    .start_adr          ( start_adr         ),
    .buf_size           ( buf_size          ),
    .fifo_data          ( fifo_data         ),
    .fifo_empty         ( fifo_empty        ),
    .fifo_rd            ( fifo_rd           ),
    .mem_address        ( mem_address       ),
    .mem_writedata      ( mem_writedata     ),
    .mem_write          ( mem_write         ),
    .mem_waitrequest    ( mem_waitrequest   ),
    .done_cnt           ( done_cnt          )
);

endmodule

// ==== tests/scan_assertions.sv ====
`timescale 1ns/10ps

module scan_assertions
(
    input  logic                    w_clk_1,
    input  logic                    w_adc_rst,
    input  logic                    si,
    input  logic                    mem_write,
    input  logic                    mem_waitrequest,
    input  mem_pkg::mem_addr_t      mem_address,
    input  logic [31:0]             mem_writedata,
    input  logic                    fifo_ovr
);

////////////////////////////////////////////////////////////////////////////
// memory port holds its beat while stalled

assert property (@(posedge w_clk_1) disable iff (w_adc_rst)
    (mem_write && mem_waitrequest) |=> ($stable(mem_address) && $stable(mem_writedata)))
    else $error("mem_address or mem_writedata changed during waitrequest");

////////////////////////////////////////////////////////////////////////////
// sensor start pulse and overflow flag

assert property (@(posedge w_clk_1) disable iff (w_adc_rst)
    si |=> !si)
    else $error("si high in two consecutive cycles");

assert property (@(posedge w_clk_1) disable iff (w_adc_rst)
    fifo_ovr |=> fifo_ovr)                          // sticky until reset
    else $error("fifo_ovr fell without reset");

endmodule

// ==== tests/scan_tb.sv ====
`timescale 1ns/10ps

module scan_tb;

localparam int LINE_CLKS      = 64;
localparam int PIX_PER_LINE   = 16;
localparam int FIFO_DEPTH     = 16;
localparam int AFULL_LEVEL    = 12;
localparam int RESET_CYCLES   = 16;
localparam int BUF_WORDS      = 12;                 // short buffer that wraps often
localparam int SI_TIMEOUT     = 2 * LINE_CLKS;
localparam int DRAIN_TIMEOUT  = 40 * LINE_CLKS;
localparam int OVR_TIMEOUT    = 12 * LINE_CLKS;
localparam mem_pkg::mem_addr_t START_ADR = 28'h0040000;
localparam logic [cis_pkg::on_cnt_w-1:0] R_ON = 16'd20;
localparam logic [cis_pkg::on_cnt_w-1:0] G_ON = 16'd11;
localparam logic [cis_pkg::on_cnt_w-1:0] B_ON = 16'd27;

logic                               w_clk_1;
logic                               w_adc_rst;
cis_pkg::adc_sample_t               dc;
cis_pkg::line_mode_t                mode;
cis_pkg::pix_src_t                  src_sel;
logic [cis_pkg::on_cnt_w-1:0]       r_on_cnt;
logic [cis_pkg::on_cnt_w-1:0]       g_on_cnt;
logic [cis_pkg::on_cnt_w-1:0]       b_on_cnt;
logic [2:0]                         lrgb;
logic                               si;
logic                               dma_on;
mem_pkg::mem_addr_t                 start_adr;
mem_pkg::mem_addr_t                 buf_size;
mem_pkg::mem_addr_t                 mem_address;
logic [31:0]                        mem_writedata;
logic                               mem_write;
logic                               mem_waitrequest;
logic [mem_pkg::done_cnt_w-1:0]     done_cnt;
logic                               fifo_afull;
logic                               fifo_ovr;

logic [31:0]                        exp_q[$];       // words still to reach memory
cis_pkg::color_t                    exp_col;
logic [5:0]                         line_idx;
logic [mem_pkg::done_cnt_w-1:0]     exp_done;
int                                 led_left;
int                                 cyc;
int                                 last_si;
int                                 beats;
int                                 wait_mode;      // 0 none, 1 random, 2 held high
logic                               have_last;
logic                               loss_ok;        // skip words dropped on overflow
logic [31:0]                        rnd;
logic [31:0]                        dc_rnd;

scan_top
#(
    .LINE_CLKS          ( LINE_CLKS         ),
    .PIX_PER_LINE       ( PIX_PER_LINE      ),
    .FIFO_DEPTH         ( FIFO_DEPTH        ),
    .AFULL_LEVEL        ( AFULL_LEVEL       )
)
u_scan_top
(
    .w_clk_1            ( w_clk_1           ),
    .w_adc_rst          ( w_adc_rst         ),
    .dc                 ( dc                ),
    .mode               ( mode              ),
    .src_sel            ( src_sel           ),
    .r_on_cnt           ( r_on_cnt          ),
    .g_on_cnt           ( g_on_cnt          ),
    .b_on_cnt           ( b_on_cnt          ),
    .lrgb               ( lrgb              ),
    .si                 ( si                ),
    .dma_on             ( dma_on            ),
    .start_adr          ( start_adr         ),
    .buf_size           ( buf_size          ),
    .mem_address        ( mem_address       ),
    .mem_writedata      ( mem_writedata     ),
    .mem_write          ( mem_write         ),
    .mem_waitrequest    ( mem_waitrequest   ),
    .done_cnt           ( done_cnt          ),
    .fifo_afull         ( fifo_afull        ),
    .fifo_ovr           ( fifo_ovr          )
);

bind scan_top scan_assertions u_scan_assertions
(
    .w_clk_1            ( w_clk_1           ),
    .w_adc_rst          ( w_adc_rst         ),
    .si                 ( si                ),
    .mem_write          ( mem_write         ),
    .mem_waitrequest    ( mem_waitrequest   ),
    .mem_address        ( mem_address       ),
    .mem_writedata      ( mem_writedata     ),
    .fifo_ovr           ( fifo_ovr          )
);

always #10 w_clk_1 = ~w_clk_1;

////////////////////////////////////////////////////////////////////////////
// reference model

function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
endfunction

function automatic cis_pkg::color_t next_color(input cis_pkg::color_t prev,
                                               input cis_pkg::line_mode_t m);
    if (m != cis_pkg::mode_rgb)
        return cis_pkg::color_red;
    case (prev)
        cis_pkg::color_red:     return cis_pkg::color_green;
        cis_pkg::color_green:   return cis_pkg::color_blue;
        default:                return cis_pkg::color_red;
    endcase
endfunction

function automatic int on_time(input cis_pkg::color_t col);
    case (col)
        cis_pkg::color_green:   return int'(G_ON);
        cis_pkg::color_blue:    return int'(B_ON);
        default:                return int'(R_ON);
    endcase
endfunction

function automatic logic [2:0] led_pattern(input cis_pkg::color_t col);
    case (col)
        cis_pkg::color_green:   return 3'b101;
        cis_pkg::color_blue:    return 3'b011;
        default:                return 3'b110;
    endcase
endfunction

// one packed word of colour, line tag and the two samples of pair p
function automatic logic [31:0] expected_word(input cis_pkg::pix_src_t src,
                                              input cis_pkg::adc_sample_t dcv,
                                              input logic [5:0] idx,
                                              input cis_pkg::color_t col,
                                              input int p);
    cis_pkg::adc_sample_t s0;
    cis_pkg::adc_sample_t s1;
    case (src)
        cis_pkg::src_ramp:
        begin
            s0 = 12'(2 * p);
            s1 = 12'(2 * p + 1);
        end
        cis_pkg::src_const:
        begin
            s0 = cis_pkg::const_pattern;
            s1 = cis_pkg::const_pattern;
        end
        default:
        begin
            s0 = dcv;
            s1 = dcv;
        end
    endcase
    return {col, idx, s0, s1};
endfunction

////////////////////////////////////////////////////////////////////////////
// error reporting

task automatic stop_run();
    $display("=== FAIL ===");
    $fatal(1, "stopped at the first error");
endtask

task automatic report_mismatch(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    $display("** Error: %s = %h, expected %h", name, got, exp);
    stop_run();
endtask

task automatic report_problem(input string what);
    $display("%s", what);
    stop_run();
endtask

////////////////////////////////////////////////////////////////////////////
// comparison process sampled 5 ns before each rising edge

task automatic track_line();
    int p;
    if (si)
    begin
        if (have_last)
            assert (cyc - last_si == LINE_CLKS)
                else report_mismatch("si period", 32'(cyc - last_si), 32'(LINE_CLKS));
        last_si   = cyc;
        have_last = 1'b1;
        exp_col   = next_color(exp_col, mode);
        led_left  = on_time(exp_col);
        for (p = 0; p < PIX_PER_LINE / 2; p++)
            exp_q.push_back(expected_word(src_sel, dc, line_idx, exp_col, p));
        line_idx = line_idx + 1'b1;
    end
    if (led_left > 0)
    begin
        assert (lrgb === led_pattern(exp_col))
            else report_mismatch("lrgb", 32'(lrgb), 32'(led_pattern(exp_col)));
        led_left--;
    end
    else
    begin
        assert (lrgb === 3'b111) else report_mismatch("lrgb", 32'(lrgb), 32'h7);
    end
endtask

task automatic check_beat();
    mem_pkg::mem_addr_t exp_adr;
    assert (done_cnt === exp_done)
        else report_mismatch("done_cnt", 32'(done_cnt), 32'(exp_done));
    if (mem_write && !mem_waitrequest)
    begin
        exp_adr = START_ADR + mem_pkg::mem_addr_t'(beats % BUF_WORDS) * mem_pkg::word_bytes;
        assert (mem_address === exp_adr)
            else report_mismatch("mem_address", 32'(mem_address), 32'(exp_adr));
        while (loss_ok && exp_q.size() > 0 && exp_q[0] !== mem_writedata)
            void'(exp_q.pop_front());           // dropped by the full fifo
        assert (exp_q.size() > 0)
            else report_problem("memory write with no expected word left");
        assert (mem_writedata === exp_q[0])
            else report_mismatch("mem_writedata", mem_writedata, exp_q[0]);
        void'(exp_q.pop_front());
        beats++;
        if (beats % BUF_WORDS == 0)
            exp_done = exp_done + 1'b1;         // buffer wrapped
    end
endtask

always
begin
    @(posedge w_clk_1);
    #15;
    if (w_adc_rst)
    begin
        exp_col   = cis_pkg::color_blue;        // so the first rgb line is red
        line_idx  = '0;
        led_left  = 0;
        have_last = 1'b0;
    end
    else
    begin
        cyc++;
        track_line();
        check_beat();
    end
end

// memory back-pressure
always
begin
    @(negedge w_clk_1);
    if (wait_mode == 1)
    begin
        rnd             = lcg_next(rnd);
        mem_waitrequest = rnd[16];
    end
    else
    begin
        mem_waitrequest = (wait_mode == 2);
    end
end

////////////////////////////////////////////////////////////////////////////
// stimulus

task automatic check_reset_state();
    assert (si === 1'b0) else report_mismatch("si", 32'(si), 32'h0);
    assert (mem_write === 1'b0) else report_mismatch("mem_write", 32'(mem_write), 32'h0);
    assert (fifo_afull === 1'b0) else report_mismatch("fifo_afull", 32'(fifo_afull), 32'h0);
    assert (fifo_ovr === 1'b0) else report_mismatch("fifo_ovr", 32'(fifo_ovr), 32'h0);
    assert (lrgb === 3'b111) else report_mismatch("lrgb", 32'(lrgb), 32'h7);
    assert (done_cnt === '0) else report_mismatch("done_cnt", 32'(done_cnt), 32'h0);
endtask

// wait for si, then move to mid-line where settings may change
task automatic next_line();
    int n;
    n = 0;
    do
    begin
        @(negedge w_clk_1);
        n++;
        if (n > SI_TIMEOUT)
            report_problem("timeout waiting for si");
    end
    while (!si);
    repeat (LINE_CLKS / 2) @(negedge w_clk_1);
endtask

task automatic wait_drain();
    int n;
    n = 0;
    while (exp_q.size() != 0 || mem_write)
    begin
        @(negedge w_clk_1);
        n++;
        if (n > DRAIN_TIMEOUT)
            report_problem("timeout waiting for the expected words to reach memory");
    end
endtask

task automatic wait_overflow();
    int   n;
    logic saw_afull;
    n         = 0;
    saw_afull = 1'b0;
    while (!fifo_ovr)
    begin
        @(negedge w_clk_1);
        assert (!fifo_ovr || saw_afull)
            else report_problem("fifo_ovr set before fifo_afull was seen");
        saw_afull = saw_afull | fifo_afull;
        n++;
        if (n > OVR_TIMEOUT)
            report_problem("timeout waiting for fifo_ovr");
    end
endtask

initial
begin
    int i;
    w_clk_1   = 1'b0;
    w_adc_rst = 1'b1;
    dc        = '0;
    mode      = cis_pkg::mode_rgb;
    src_sel   = cis_pkg::src_ramp;
    r_on_cnt  = R_ON;
    g_on_cnt  = G_ON;
    b_on_cnt  = B_ON;
    dma_on    = 1'b1;
    start_adr = START_ADR;
    buf_size  = mem_pkg::mem_addr_t'(BUF_WORDS);
    mem_waitrequest = 1'b0;
    wait_mode = 0;
    loss_ok   = 1'b0;
    exp_done  = '0;
    cyc       = 0;
    last_si   = 0;
    beats     = 0;
    rnd       = 32'd50;
    dc_rnd    = 32'd50;

    for (i = 0; i < RESET_CYCLES; i++)
    begin
        @(negedge w_clk_1);
        if (i > 0)
            check_reset_state();
    end
    w_adc_rst = 1'b0;
    @(negedge w_clk_1);
    check_reset_state();

    repeat (6) next_line();                     // rgb, ramp, no wait
    src_sel = cis_pkg::src_adc;
    for (i = 0; i < 3; i++)
    begin
        dc_rnd = lcg_next(dc_rnd);
        dc     = dc_rnd[27:16];
        next_line();
    end
    src_sel = cis_pkg::src_const;
    repeat (2) next_line();

    mode      = cis_pkg::mode_mono;             // random back-pressure
    src_sel   = cis_pkg::src_ramp;
    wait_mode = 1;
    repeat (8) next_line();
    mode      = cis_pkg::mode_off;
    have_last = 1'b0;
    wait_drain();

    // overflow with the port stalled for several lines
    loss_ok   = 1'b1;
    wait_mode = 2;
    mode      = cis_pkg::mode_mono;
    wait_overflow();
    repeat (2) next_line();
    wait_mode = 0;
    repeat (3) next_line();
    mode      = cis_pkg::mode_off;
    wait_drain();

    if (exp_q.size() == 0 && fifo_ovr)
    begin
        $display("=== PASS ===");
        $finish;
    end
    else
    begin
        report_problem("words left unwritten or overflow flag cleared at the end");
    end
end

endmodule

// ==== tb.f ====
verilog/cis_pkg.sv
verilog/mem_pkg.sv
verilog/cis_line_sequencer.sv
verilog/pixel_packer.sv
verilog/pixel_fifo.sv
verilog/sdram_writer.sv
verilog/scan_top.sv
tests/scan_assertions.sv
tests/scan_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the capture path testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f tb.f \
    --top-module scan_tb \
    -Mdir obj_dir \
    -o scan_sim

./obj_dir/scan_sim | tee sim.log

if grep -qx "=== PASS ===" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
